//--- src/mimic_pkg.sv
// Assumes the fixed 32-bit instruction format below; opcode values are local to this core.
`default_nettype none

package mimic_pkg;

   typedef logic [31:0] word_t;
   typedef logic [7:0]  byte_t;
   typedef logic [15:0] iaddr_t;
   typedef logic [4:0]  reg_addr_t;
   typedef logic [5:0]  opcode_t;

   typedef enum logic [1:0] {
      st_load,
      st_fetch,
      st_exec,
      st_halt
   } core_state_t;

   // instruction field positions.
   localparam int OPC_HI   = 31;
   localparam int OPC_LO   = 26;
   localparam int RS_HI    = 25;
   localparam int RS_LO    = 21;
   localparam int RT_HI    = 20;
   localparam int RT_LO    = 16;
   localparam int RD_HI    = 15;
   localparam int RD_LO    = 11;
   localparam int IMM_HI   = 15;
   localparam int IMM_LO   = 0;
   localparam int FUNCT_HI = 5;
   localparam int FUNCT_LO = 0;

   localparam int IMEM_DEPTH  = 1024;
   localparam int IMEM_ADDR_W = 10;
   localparam int NUM_REGS    = 32;

   localparam opcode_t OP_RTYPE = 6'h00;
   localparam opcode_t OP_J     = 6'h02;
   localparam opcode_t OP_BEQ   = 6'h04;
   localparam opcode_t OP_BNE   = 6'h05;
   localparam opcode_t OP_ADDI  = 6'h08;
   localparam opcode_t OP_SEND  = 6'h3c;
   localparam opcode_t OP_RECV  = 6'h3d;
   localparam opcode_t OP_HALT  = 6'h3f;

   // function codes, only meaningful under OP_RTYPE.
   localparam logic [5:0] F_ADD = 6'h20;
   localparam logic [5:0] F_SUB = 6'h22;
   localparam logic [5:0] F_AND = 6'h24;
   localparam logic [5:0] F_OR  = 6'h25;
   localparam logic [5:0] F_SLT = 6'h2a;

endpackage

`default_nettype wire

//--- src/instruction_loader.sv
// Expects a big-endian 16-bit word count and then big-endian words; a zero count restarts loading.
`timescale 1ns/1ps
`default_nettype none

module instruction_loader (
   input  wire               clk,
   input  wire               rst,
   input  wire mimic_pkg::byte_t rx_received_data,
   input  wire               byte_accept,
   output logic              byte_wanted,
   output mimic_pkg::iaddr_t write_address,
   output mimic_pkg::word_t  write_data,
   output logic              write_enable,
   output logic              in_execution
);
   import mimic_pkg::*;

   logic        active;
   logic        have_count;
   logic        last_written;
   logic [1:0]  byte_index;
   logic [23:0] shift;
   iaddr_t      remaining;
   iaddr_t      count;
   logic        take;

   // active holds off any pop during the first cycle out of reset.
   assign byte_wanted  = active && !in_execution && !last_written;
   assign take         = byte_accept && byte_wanted;
   assign count        = {shift[7:0], rx_received_data};
   assign write_data   = {shift, rx_received_data};
   assign write_enable = take && have_count && (byte_index == 2'd3);

   always_ff @(posedge clk) begin
      if (take) begin
         shift <= {shift[15:0], rx_received_data};
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         active        <= 1'b0;
         have_count    <= 1'b0;
         last_written  <= 1'b0;
         byte_index    <= 2'd0;
         remaining     <= '0;
         write_address <= '0;
         in_execution  <= 1'b0;
      end else begin
         active <= 1'b1;
         if (last_written) begin
            in_execution <= 1'b1;
            last_written <= 1'b0;
         end
         if (take) begin
            if (!have_count) begin
               if (byte_index == 2'd0) begin
                  byte_index <= 2'd1;
               end else begin
                  byte_index <= 2'd0;
                  remaining  <= count;
                  have_count <= (count != '0);
               end
            end else begin
               // the index wraps from 3 back to 0 at the end of each word.
               byte_index <= byte_index + 2'd1;
               if (byte_index == 2'd3) begin
                  write_address <= write_address + 16'd1;
                  remaining     <= remaining - 16'd1;
                  if (remaining == 16'd1) begin
                     have_count   <= 1'b0;
                     last_written <= 1'b1;
                  end
               end
            end
         end
      end
   end

endmodule

`default_nettype wire

//--- src/instruction_memory.sv
// Only the low ten address bits select a word; contents are undefined until loaded.
`timescale 1ns/1ps
`default_nettype none

module instruction_memory (
   input  wire                    clk,
   input  wire mimic_pkg::iaddr_t address,
   input  wire mimic_pkg::word_t  write_data,
   input  wire                    write_enable,
   output mimic_pkg::word_t       read_data
);
   import mimic_pkg::*;

   word_t                  mem [IMEM_DEPTH];
   logic [IMEM_ADDR_W-1:0] index;

   assign index = address[IMEM_ADDR_W-1:0];

   // read data shows the word at the address of the previous edge.
   always_ff @(posedge clk) begin
      if (write_enable) begin
         mem[index] <= write_data;
      end
      read_data <= mem[index];
   end

endmodule

`default_nettype wire

//--- src/cpu_control.sv
// Two cycles per instruction; pc is a word address and branch offsets wrap at 16 bits.
`timescale 1ns/1ps
`default_nettype none

module cpu_control (
   input  wire                         clk,
   input  wire                         rst,
   input  wire                         in_execution,
   input  wire mimic_pkg::iaddr_t      load_address,
   input  wire mimic_pkg::word_t       instruction,
   output mimic_pkg::iaddr_t           memory_address,
   output mimic_pkg::reg_addr_t        rs_addr,
   output mimic_pkg::reg_addr_t        rt_addr,
   input  wire mimic_pkg::word_t       rs_data,
   input  wire mimic_pkg::word_t       rt_data,
   input  wire mimic_pkg::word_t       alu_result,
   input  wire                         branch_taken,
   input  wire mimic_pkg::byte_t       rx_received_data,
   output logic                        recv_request,
   input  wire                         recv_ready,
   output logic                        send_request,
   output mimic_pkg::byte_t            send_data,
   output logic                        reg_write_enable,
   output mimic_pkg::reg_addr_t        reg_write_addr,
   output mimic_pkg::word_t            reg_write_data,
   output logic                        halted
);
   import mimic_pkg::*;

   core_state_t state;
   iaddr_t      pc;
   iaddr_t      pc_plus;
   iaddr_t      branch_target;
   iaddr_t      next_pc;
   opcode_t     opcode;
   logic        exec_cycle;
   logic        recv_stall;

   assign opcode     = instruction[OPC_HI:OPC_LO];
   assign rs_addr    = instruction[RS_HI:RS_LO];
   assign rt_addr    = instruction[RT_HI:RT_LO];
   assign exec_cycle = (state == st_exec);
   assign halted     = (state == st_halt);

   // the loader owns the memory port until execution begins.
   assign memory_address = in_execution ? pc : load_address;

   assign pc_plus       = pc + 16'd1;
   assign branch_target = pc_plus + instruction[IMM_HI:IMM_LO];

   assign recv_request = exec_cycle && (opcode == OP_RECV);
   assign recv_stall   = recv_request && !recv_ready;
   assign send_request = exec_cycle && (opcode == OP_SEND);
   assign send_data    = rt_data[7:0];

   always_comb begin
      reg_write_enable = 1'b0;
      reg_write_addr   = rt_addr;
      reg_write_data   = alu_result;
      case (opcode)
         OP_RTYPE: begin
            reg_write_enable = exec_cycle;
            reg_write_addr   = instruction[RD_HI:RD_LO];
         end
         OP_ADDI: reg_write_enable = exec_cycle;
         OP_RECV: begin
            reg_write_enable = recv_request && recv_ready;
            reg_write_data   = {24'd0, rx_received_data};
         end
         default: reg_write_enable = 1'b0;
      endcase
   end

   always_comb begin
      case (opcode)
         OP_BEQ, OP_BNE: next_pc = branch_taken ? branch_target : pc_plus;
         OP_J:           next_pc = instruction[IMM_HI:IMM_LO];
         default:        next_pc = pc_plus;
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         state <= st_load;
         pc    <= '0;
      end else begin
         case (state)
            st_load: begin
               if (in_execution) begin
                  state <= st_fetch;
               end
            end
            st_fetch: state <= st_exec;
            st_exec: begin
               if (opcode == OP_HALT) begin
                  state <= st_halt;
               end else if (!recv_stall) begin
                  pc    <= next_pc;
                  state <= st_fetch;
               end
            end
            default: state <= st_halt;
         endcase
      end
   end

endmodule

`default_nettype wire

//--- src/register_file.sv
// Register 0 reads as zero; a read in the cycle of a write to it returns the old value.
`timescale 1ns/1ps
`default_nettype none

module register_file (
   input  wire                          clk,
   input  wire                          rst,
   input  wire mimic_pkg::reg_addr_t    rs_addr,
   input  wire mimic_pkg::reg_addr_t    rt_addr,
   output mimic_pkg::word_t             rs_data,
   output mimic_pkg::word_t             rt_data,
   input  wire                          write_enable,
   input  wire mimic_pkg::reg_addr_t    write_addr,
   input  wire mimic_pkg::word_t        write_data
);
   import mimic_pkg::*;

   word_t regs [NUM_REGS];

   assign rs_data = (rs_addr == '0) ? '0 : regs[rs_addr];
   assign rt_data = (rt_addr == '0) ? '0 : regs[rt_addr];

   always_ff @(posedge clk) begin
      if (rst) begin
         for (int i = 0; i < NUM_REGS; i++) begin
            regs[i] <= '0;
         end
      end else if (write_enable && (write_addr != '0)) begin
         regs[write_addr] <= write_data;
      end
   end

endmodule

`default_nettype wire

//--- src/alu_unit.sv
// Purely combinational; results for opcodes that write nothing are zero.
`timescale 1ns/1ps
`default_nettype none

module alu_unit (
   input  wire mimic_pkg::word_t instruction,
   input  wire mimic_pkg::word_t rs_data,
   input  wire mimic_pkg::word_t rt_data,
   output mimic_pkg::word_t      result,
   output logic                  branch_taken
);
   import mimic_pkg::*;

   opcode_t    opcode;
   logic [5:0] funct;
   word_t      imm_ext;

   assign opcode  = instruction[OPC_HI:OPC_LO];
   assign funct   = instruction[FUNCT_HI:FUNCT_LO];
   assign imm_ext = {{16{instruction[IMM_HI]}}, instruction[IMM_HI:IMM_LO]};

   always_comb begin
      result = '0;
      case (opcode)
         OP_RTYPE: begin
            case (funct)
               F_ADD:   result = rs_data + rt_data;
               F_SUB:   result = rs_data - rt_data;
               F_AND:   result = rs_data & rt_data;
               F_OR:    result = rs_data | rt_data;
               // signed compare.
               F_SLT:   result = {31'd0, $signed(rs_data) < $signed(rt_data)};
               default: result = '0;
            endcase
         end
         OP_ADDI: result = rs_data + imm_ext;
         default: result = '0;
      endcase
   end

   always_comb begin
      case (opcode)
         OP_BEQ:  branch_taken = (rs_data == rt_data);
         OP_BNE:  branch_taken = (rs_data != rt_data);
         default: branch_taken = 1'b0;
      endcase
   end

endmodule

`default_nettype wire

//--- src/serial_port.sv
// The receive FIFO must be first-word-fall-through; transmit has no flow control.
`timescale 1ns/1ps
`default_nettype none

module serial_port (
   input  wire                    clk,
   input  wire                    rst,
   input  wire                    in_execution,
   input  wire                    byte_wanted,
   input  wire                    recv_request,
   output logic                   recv_ready,
   input  wire                    send_request,
   input  wire mimic_pkg::byte_t  send_data,
   input  wire                    rx_waiting,
   output logic                   rx_fifo_pop,
   output logic                   tx_send_enable,
   output mimic_pkg::byte_t       tx_send_data
);

   // the loader owns the receive side until execution starts.
   assign recv_ready  = in_execution && recv_request && !rx_waiting;
   assign rx_fifo_pop = !rx_waiting && (in_execution ? recv_request : byte_wanted);

   always_ff @(posedge clk) begin
      if (rst) begin
         tx_send_enable <= 1'b0;
      end else begin
         tx_send_enable <= send_request;
      end
   end

   always_ff @(posedge clk) begin
      if (send_request) begin
         tx_send_data <= send_data;
      end
   end

endmodule

`default_nettype wire

//--- src/mimic.sv
// Loads a program from the serial input after every reset, then runs it from address 0.
`timescale 1ns/1ps
`default_nettype none

module mimic (
   input  wire                   clk,
   input  wire                   rst,
   input  wire mimic_pkg::byte_t rx_received_data,
   input  wire                   rx_waiting,
   output logic                  rx_fifo_pop,
   output logic                  tx_send_enable,
   output mimic_pkg::byte_t      tx_send_data,
   output logic                  in_execution,
   output logic                  halted
);
   import mimic_pkg::*;

   wire iaddr_t    load_address;
   wire word_t     load_data;
   wire            load_enable;
   wire            byte_wanted;
   wire iaddr_t    memory_address;
   wire word_t     instruction;
   wire reg_addr_t rs_addr;
   wire reg_addr_t rt_addr;
   wire word_t     rs_data;
   wire word_t     rt_data;
   wire word_t     alu_result;
   wire            branch_taken;
   wire            recv_request;
   wire            recv_ready;
   wire            send_request;
   wire byte_t     send_data;
   wire            reg_write_enable;
   wire reg_addr_t reg_write_addr;
   wire word_t     reg_write_data;

   instruction_loader loader_inst (
      .clk(clk), .rst(rst), .rx_received_data(rx_received_data),
      .byte_accept(rx_fifo_pop), .byte_wanted(byte_wanted),
      .write_address(load_address), .write_data(load_data),
      .write_enable(load_enable), .in_execution(in_execution));

   instruction_memory imem_inst (
      .clk(clk), .address(memory_address), .write_data(load_data),
      .write_enable(load_enable), .read_data(instruction));

   cpu_control control_inst (
      .clk(clk), .rst(rst), .in_execution(in_execution),
      .load_address(load_address), .instruction(instruction),
      .memory_address(memory_address), .rs_addr(rs_addr), .rt_addr(rt_addr),
      .rs_data(rs_data), .rt_data(rt_data), .alu_result(alu_result),
      .branch_taken(branch_taken), .rx_received_data(rx_received_data),
      .recv_request(recv_request), .recv_ready(recv_ready),
      .send_request(send_request), .send_data(send_data),
      .reg_write_enable(reg_write_enable), .reg_write_addr(reg_write_addr),
      .reg_write_data(reg_write_data), .halted(halted));

   register_file regs_inst (
      .clk(clk), .rst(rst), .rs_addr(rs_addr), .rt_addr(rt_addr),
      .rs_data(rs_data), .rt_data(rt_data), .write_enable(reg_write_enable),
      .write_addr(reg_write_addr), .write_data(reg_write_data));

   alu_unit alu_inst (
      .instruction(instruction), .rs_data(rs_data), .rt_data(rt_data),
      .result(alu_result), .branch_taken(branch_taken));

   serial_port serial_inst (
      .clk(clk), .rst(rst), .in_execution(in_execution), .byte_wanted(byte_wanted),
      .recv_request(recv_request), .recv_ready(recv_ready),
      .send_request(send_request), .send_data(send_data),
      .rx_waiting(rx_waiting), .rx_fifo_pop(rx_fifo_pop),
      .tx_send_enable(tx_send_enable), .tx_send_data(tx_send_data));

endmodule

`default_nettype wire

//--- test/tb_mimic.sv
// Run from the project root so test/mimic_cases.txt is found; each case starts with a reset.
`timescale 1ns/1ps
`default_nettype none

module tb_mimic;

   localparam int IDLE_CYCLES = 20;
   localparam int CASE_SLACK  = 40;

   logic        clk;
   logic        rst;
   logic [7:0]  rx_received_data;
   logic        rx_waiting;
   wire         rx_fifo_pop;
   wire         tx_send_enable;
   wire  [7:0]  tx_send_data;
   wire         in_execution;
   wire         halted;

   logic [7:0]  cases_mem [0:1023];
   logic [7:0]  rx_q [$];
   logic [7:0]  tx_q [$];
   logic [31:0] rand_state;
   int          rd_ptr;
   int          prog_len;
   int          popped;
   int          gap;
   int          value_errors;
   int          other_errors;
   int          tx_checked;
   int          cycles;
   int          limit;

   mimic uut (
      .clk(clk), .rst(rst), .rx_received_data(rx_received_data),
      .rx_waiting(rx_waiting), .rx_fifo_pop(rx_fifo_pop),
      .tx_send_enable(tx_send_enable), .tx_send_data(tx_send_data),
      .in_execution(in_execution), .halted(halted));

   initial clk = 1'b0;
   always #50 clk = ~clk;

   always @(posedge clk) begin
      cycles = cycles + 1;
      if (cycles > limit) begin
         $display("timeout: run did not finish within %0d cycles", limit);
         $display("Done: errors found");
         $finish;
      end
   end

   function automatic logic [31:0] xorshift(logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   function automatic logic [7:0] next_byte();
      logic [7:0] b;
      b = cases_mem[rd_ptr];
      rd_ptr = rd_ptr + 1;
      return b;
   endfunction

   // the FIFO head is visible only when no gap is pending.
   task automatic show_head();
      if (gap == 0 && rx_q.size() > 0) begin
         rx_waiting = 1'b0;
         rx_received_data = rx_q[0];
      end else begin
         rx_waiting = 1'b1;
         rx_received_data = 8'h00;
      end
   endtask

   task automatic run_cycle();
      logic pop;
      @(negedge clk);
      pop = rx_fifo_pop;
      if (in_execution && popped < prog_len) begin
         $display("in_execution high at %0t before the program was fully received", $time);
         other_errors++;
      end
      if (tx_send_enable) begin
         if (!in_execution) begin
            $display("tx byte at %0t while the program was still loading", $time);
            other_errors++;
         end else if (tx_q.size() == 0) begin
            $display("unexpected tx byte %h at %0t", tx_send_data, $time);
            other_errors++;
         end else begin
            tx_checked++;
            if (tx_send_data !== tx_q[0]) begin
               $display("error at %0t: tx_send_data got %h expected %h",
                        $time, tx_send_data, tx_q[0]);
               value_errors++;
            end
            void'(tx_q.pop_front());
         end
      end
      @(posedge clk);
      #1;
      if (pop) begin
         if (rx_waiting) begin
            $display("rx_fifo_pop at %0t while the FIFO was empty", $time);
            other_errors++;
         end else begin
            void'(rx_q.pop_front());
            popped++;
            rand_state = xorshift(rand_state);
            gap = int'(rand_state[1:0]);
         end
      end else if (gap > 0) begin
         gap--;
      end
      show_head();
   endtask

   task automatic apply_reset();
      rst = 1'b1;
      rx_q.delete();
      tx_q.delete();
      gap = 0;
      popped = 0;
      prog_len = 0;
      show_head();
      repeat (4) @(posedge clk);
      #1;
      rst = 1'b0;
      if (in_execution || halted || tx_send_enable) begin
         $display("control outputs still active after reset at %0t", $time);
         other_errors++;
      end
   endtask

   task automatic run_case(int index);
      logic [7:0] flag_byte;
      logic       reset_flag;
      int         n;
      flag_byte = next_byte();
      reset_flag = flag_byte[0];
      // a case that ends running is stopped by the reset of the following case.
      apply_reset();
      prog_len = int'(next_byte());
      for (int i = 0; i < prog_len; i++) rx_q.push_back(next_byte());
      n = int'(next_byte());
      for (int i = 0; i < n; i++) rx_q.push_back(next_byte());
      n = int'(next_byte());
      for (int i = 0; i < n; i++) tx_q.push_back(next_byte());
      void'(next_byte());
      show_head();
      // the first program byte is already shown, but no pop may follow it yet.
      #1;
      if (rx_fifo_pop) begin
         $display("rx_fifo_pop high in the first cycle after reset at %0t", $time);
         other_errors++;
      end
      while (reset_flag ? tx_q.size() > 0 : !halted) run_cycle();
      repeat (IDLE_CYCLES) run_cycle();
      if (tx_q.size() != 0) begin
         $display("case %0d: %0d expected tx bytes never arrived", index, tx_q.size());
         other_errors++;
      end
      if (rx_q.size() != 0) begin
         $display("case %0d: %0d receive bytes were left unread", index, rx_q.size());
         other_errors++;
      end
      if (reset_flag && (!in_execution || halted)) begin
         $display("case %0d: core stopped before the mid-run reset", index);
         other_errors++;
      end else if (!reset_flag && !halted) begin
         $display("case %0d: halted dropped after the halt", index);
         other_errors++;
      end
   endtask

   task automatic compute_limit(int num_cases);
      int total;
      int n;
      total = 0;
      rd_ptr = 1;
      for (int c = 0; c < num_cases; c++) begin
         void'(next_byte());
         n = int'(next_byte());
         total = total + 20 * n;
         rd_ptr = rd_ptr + n;
         n = int'(next_byte());
         total = total + 20 * n;
         rd_ptr = rd_ptr + n;
         n = int'(next_byte());
         rd_ptr = rd_ptr + n;
         n = int'(next_byte());
         total = total + 10 * n + CASE_SLACK;
      end
      limit = total;
      rd_ptr = 1;
   endtask

   initial begin
      int num_cases;
      rst = 1'b1;
      rx_waiting = 1'b1;
      rx_received_data = 8'h00;
      rand_state = 32'd29;
      value_errors = 0;
      other_errors = 0;
      tx_checked = 0;
      cycles = 0;
      limit = 1000;
      gap = 0;
      popped = 0;
      prog_len = 0;
      $readmemh("test/mimic_cases.txt", cases_mem);
      num_cases = int'(cases_mem[0]);
      if (num_cases == 0) begin
         $display("no test cases read from test/mimic_cases.txt");
         other_errors++;
      end
      compute_limit(num_cases);
      for (int c = 0; c < num_cases; c++) run_case(c);
      $display("%0d tx bytes checked, %0d value errors, %0d other errors",
               tx_checked, value_errors, other_errors);
      if (value_errors + other_errors == 0) begin
         $display("Done: no errors");
      end else begin
         $display("Done: errors found");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- flist.f
src/mimic_pkg.sv
src/instruction_loader.sv
src/instruction_memory.sv
src/cpu_control.sv
src/register_file.sv
src/alu_unit.sv
src/serial_port.sv
src/mimic.sv
test/tb_mimic.sv

//--- Makefile
# Verilator flow for the mimic processor and its testbench.
# Override on the command line, for example: make sim TOP=tb_mimic LOG=run.log

VERILATOR ?= verilator
TOP       ?= tb_mimic
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing
FLIST     ?= flist.f

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FLIST)

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

sim: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Done: errors found" $(LOG); then echo "FAIL: see $(LOG)"; exit 1; fi
	@echo "PASS"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- test/mimic_cases.txt
// per case: reset_flag, program byte count, program bytes, rx byte count, rx bytes,
// tx byte count, expected tx bytes, instructions executed (used for the run limit only)
05
// arithmetic with add, sub, and, or, slt and addi; writes to register 0 are dropped.
00 4e 00 13
20 01 00 05 20 02 ff fd 00 22 18 20 f0 03 00 00 00 22 20 22 f0 04 00 00
00 22 28 24 f0 05 00 00 00 22 30 25 f0 06 00 00 00 41 38 2a f0 07 00 00
00 22 40 2a f0 08 00 00 20 20 00 07 f0 00 00 00 20 29 00 7b f0 09 00 00
fc 00 00 00
00
08 02 08 05 fd 01 00 00 80
13
// counting loop with bne, a beq skip, a jump and a beq that falls through.
00 36 00 0d
20 01 00 03 f0 01 00 00 20 21 ff ff 14 20 ff fd 10 20 00 01 f0 01 00 00
20 02 00 41 08 00 00 09 f0 02 00 00 f0 02 00 00 10 40 00 01 f0 01 00 00
fc 00 00 00
00
05 03 02 01 41 00
11
// recv echo loop, each byte plus 0x10.
00 1e 00 07
f4 01 00 00 20 21 00 10 f0 01 00 00 20 42 00 01 20 03 00 04 14 43 ff fa
fc 00 00 00
04 3a 00 f5 7e
04 4a 10 05 8e
19
// sends one byte and then spins on a jump until the next reset.
01 0e 00 03
20 01 00 99 f0 01 00 00 08 00 00 02
00
01 99
10
// a zero count first, then a short program after the mid-run reset.
00 10 00 00 00 03
20 01 00 2c f0 01 00 00 fc 00 00 00
00
01 2c
03
